/* run_sim.sh */
#!/bin/sh
# Build and run the game input path testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -f tb.f \
    --top-module tb_board_inputs -Mdir obj_dir > "$LOG" 2>&1 \
    && ./obj_dir/Vtb_board_inputs >> "$LOG" 2>&1
cat "$LOG"

grep -q "Verification failed" "$LOG" && exit 1
grep -q "Verification passed" "$LOG" || { echo "No test result in $LOG"; exit 1; }
exit 0

/* source/board_inputs.sv */
//----------------------------------------------------------------------
// Game input path top level: sampler, OSD decode, one channel per
// player and the output mapper, with plain board and game ports
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module board_inputs #(
    parameter int ACTIVE_LOW = 1
) (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  logic                              vs,
    input  logic                              downloading,
    input  logic [board_pkg::JOY_W-1:0]       board_joystick1,
    input  logic [board_pkg::JOY_W-1:0]       board_joystick2,
    input  logic [board_pkg::JOY_W-1:0]       board_joystick3,
    input  logic [board_pkg::JOY_W-1:0]       board_joystick4,
    input  logic [board_pkg::JOY_W-1:0]       key_joystick1,
    input  logic [board_pkg::JOY_W-1:0]       key_joystick2,
    input  logic [board_pkg::JOY_W-1:0]       key_joystick3,
    input  logic [board_pkg::JOY_W-1:0]       key_joystick4,
    input  logic [board_pkg::NUM_PLAYERS-1:0] board_coin,
    input  logic [board_pkg::NUM_PLAYERS-1:0] board_start,
    input  logic [board_pkg::STATUS_W-1:0]    status,
    input  logic                              key_pause,
    output logic [board_pkg::JOY_W-1:0]       game_joystick1,
    output logic [board_pkg::JOY_W-1:0]       game_joystick2,
    output logic [board_pkg::JOY_W-1:0]       game_joystick3,
    output logic [board_pkg::JOY_W-1:0]       game_joystick4,
    output logic [board_pkg::NUM_PLAYERS-1:0] game_coin,
    output logic [board_pkg::NUM_PLAYERS-1:0] game_start,
    output logic                              dip_pause,
    output logic                              dip_test
);
    import board_pkg::*;

    logic [JOY_W-1:0] board_joy [NUM_PLAYERS];
    logic [JOY_W-1:0] key_joy [NUM_PLAYERS];
    logic [JOY_W-1:0] game_joy [NUM_PLAYERS];
    player_state_t    states [NUM_PLAYERS];
    logic             flip;
    logic             autofire_en;
    logic             test;
    logic             game_pause;

    player_if players [NUM_PLAYERS] ();

    // Board ports into per-player arrays
    assign board_joy[0] = board_joystick1;
    assign board_joy[1] = board_joystick2;
    assign board_joy[2] = board_joystick3;
    assign board_joy[3] = board_joystick4;

    assign key_joy[0] = key_joystick1;
    assign key_joy[1] = key_joystick2;
    assign key_joy[2] = key_joystick3;
    assign key_joy[3] = key_joystick4;

    assign game_joystick1 = game_joy[0];
    assign game_joystick2 = game_joy[1];
    assign game_joystick3 = game_joy[2];
    assign game_joystick4 = game_joy[3];

    input_sampler i_sampler (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .vs          (vs),
        .downloading (downloading),
        .board_joy   (board_joy),
        .key_joy     (key_joy),
        .board_coin  (board_coin),
        .board_start (board_start),
        .players     (players)
    );

    osd_dip_decode i_dip (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .status      (status),
        .key_pause   (key_pause),
        .flip        (flip),
        .autofire_en (autofire_en),
        .test        (test),
        .game_pause  (game_pause)
    );

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        player_channel i_channel (
            .clk_sys     (clk_sys),
            .rst         (rst),
            .raw         (players[p]),
            .flip        (flip),
            .autofire_en (autofire_en),
            .state       (states[p])
        );
    end

    game_port_mapper #(
        .ACTIVE_LOW (ACTIVE_LOW)
    ) i_mapper (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .states     (states),
        .game_pause (game_pause),
        .test       (test),
        .game_joy   (game_joy),
        .game_coin  (game_coin),
        .game_start (game_start),
        .dip_pause  (dip_pause),
        .dip_test   (dip_test)
    );

endmodule

`default_nettype wire

/* source/board_pkg.sv */
//----------------------------------------------------------------------
// Shared definitions of the game input path: widths, OSD status bit
// positions, joystick bit layout and the per-player state struct
//----------------------------------------------------------------------
`default_nettype none

package board_pkg;

    // One joystick word holds four directions and six buttons
    localparam int JOY_W       = 10;
    localparam int NUM_PLAYERS = 4;

    // OSD status word from the board firmware
    localparam int STATUS_W = 64;

    localparam int STATUS_PAUSE_BIT    = 1;
    localparam int STATUS_FLIP_BIT     = 2;
    localparam int STATUS_TEST_BIT     = 10;
    localparam int STATUS_AUTOFIRE_BIT = 18;

    // Direction bits
    localparam int JOY_RIGHT = 0;
    localparam int JOY_LEFT  = 1;
    localparam int JOY_DOWN  = 2;
    localparam int JOY_UP    = 3;

    // First button, the others follow up to bit 9
    localparam int JOY_BTN0 = 4;

    // Game side view of one player, active high
    typedef struct packed {
        logic [JOY_W-1:0] joy;
        logic             coin;
        logic             start;
    } player_state_t;

endpackage

`default_nettype wire

/* source/game_port_mapper.sv */
//----------------------------------------------------------------------
// Game port mapper: registers the player states and the DIP flags and
// drives them at the polarity the game core expects
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module game_port_mapper #(
    parameter int ACTIVE_LOW = 1
) (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  board_pkg::player_state_t          states [board_pkg::NUM_PLAYERS],
    input  logic                              game_pause,
    input  logic                              test,
    output logic [board_pkg::JOY_W-1:0]       game_joy [board_pkg::NUM_PLAYERS],
    output logic [board_pkg::NUM_PLAYERS-1:0] game_coin,
    output logic [board_pkg::NUM_PLAYERS-1:0] game_start,
    output logic                              dip_pause,
    output logic                              dip_test
);
    import board_pkg::*;

    localparam bit                     INV      = (ACTIVE_LOW != 0);
    localparam logic [JOY_W-1:0]       JOY_IDLE = {JOY_W{INV}};
    localparam logic [NUM_PLAYERS-1:0] BIT_IDLE = {NUM_PLAYERS{INV}};

    logic any_active;
    logic outputs_idle;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                game_joy[p] <= JOY_IDLE;
            end
            game_coin  <= BIT_IDLE;
            game_start <= BIT_IDLE;
            dip_pause  <= 1'b0;
            dip_test   <= 1'b0;
        end else begin
            // XOR with the idle level gives the game polarity
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                game_joy[p]   <= states[p].joy ^ JOY_IDLE;
                game_coin[p]  <= states[p].coin ^ INV;
                game_start[p] <= states[p].start ^ INV;
            end
            dip_pause <= game_pause;
            dip_test  <= test;
        end
    end

    // Idle detection for the polarity check
    always_comb begin
        any_active   = 1'b0;
        outputs_idle = (game_coin == BIT_IDLE) && (game_start == BIT_IDLE);
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            any_active   = any_active | (|states[p]);
            outputs_idle = outputs_idle && (game_joy[p] == JOY_IDLE);
        end
    end

    assert property (@(posedge clk_sys) disable iff (rst) !any_active |=> outputs_idle)
        else $error("game outputs not at the inactive level with no input active");

endmodule

`default_nettype wire

/* source/input_sampler.sv */
//----------------------------------------------------------------------
// Board input sampler: two-flop synchroniser, keyboard alignment
// stage, vertical sync edge detector and download lock
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module input_sampler (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  logic                              vs,
    input  logic                              downloading,
    input  logic [board_pkg::JOY_W-1:0]       board_joy [board_pkg::NUM_PLAYERS],
    input  logic [board_pkg::JOY_W-1:0]       key_joy [board_pkg::NUM_PLAYERS],
    input  logic [board_pkg::NUM_PLAYERS-1:0] board_coin,
    input  logic [board_pkg::NUM_PLAYERS-1:0] board_start,
    player_if.source                          players [board_pkg::NUM_PLAYERS]
);
    import board_pkg::*;

    logic [JOY_W-1:0]       joy_meta [NUM_PLAYERS];
    logic [JOY_W-1:0]       joy_sync [NUM_PLAYERS];
    logic [JOY_W-1:0]       key_q [NUM_PLAYERS];
    logic [JOY_W-1:0]       key_sync [NUM_PLAYERS];
    logic [NUM_PLAYERS-1:0] coin_meta;
    logic [NUM_PLAYERS-1:0] coin_sync;
    logic [NUM_PLAYERS-1:0] start_meta;
    logic [NUM_PLAYERS-1:0] start_sync;
    logic                   vs_meta;
    logic                   vs_sync;
    logic                   vs_last;
    logic                   frame_tick;

    // Second stage carries the download lock, keyboard shares it
    // so both sources arrive on the same cycle
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                joy_meta[p] <= '0;
                joy_sync[p] <= '0;
                key_q[p]    <= '0;
                key_sync[p] <= '0;
            end
            coin_meta  <= '0;
            coin_sync  <= '0;
            start_meta <= '0;
            start_sync <= '0;
        end else begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                joy_meta[p] <= board_joy[p];
                key_q[p]    <= key_joy[p];
                joy_sync[p] <= downloading ? '0 : joy_meta[p];
                key_sync[p] <= downloading ? '0 : key_q[p];
            end
            coin_meta  <= board_coin;
            start_meta <= board_start;
            coin_sync  <= downloading ? '0 : coin_meta;
            start_sync <= downloading ? '0 : start_meta;
        end
    end

    // Frame tick from the rising edge of the synchronised vs
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            vs_meta    <= 1'b0;
            vs_sync    <= 1'b0;
            vs_last    <= 1'b0;
            frame_tick <= 1'b0;
        end else begin
            vs_meta    <= vs;
            vs_sync    <= vs_meta;
            vs_last    <= vs_sync;
            frame_tick <= vs_sync & ~vs_last;
        end
    end

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_drive
        assign players[p].board_joy  = joy_sync[p];
        assign players[p].key_joy    = key_sync[p];
        assign players[p].coin       = coin_sync[p];
        assign players[p].start      = start_sync[p];
        assign players[p].frame_tick = frame_tick;
    end

    // Channels count each tick as one frame
    assert property (@(posedge clk_sys) disable iff (rst) frame_tick |=> !frame_tick)
        else $error("frame_tick high on two consecutive cycles");

endmodule

`default_nettype wire

/* source/osd_dip_decode.sv */
//----------------------------------------------------------------------
// OSD status decoding into flip, autofire, test and pause, with the
// keyboard pause toggle
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module osd_dip_decode (
    input  logic                           clk_sys,
    input  logic                           rst,
    input  logic [board_pkg::STATUS_W-1:0] status,
    input  logic                           key_pause,
    output logic                           flip,
    output logic                           autofire_en,
    output logic                           test,
    output logic                           game_pause
);
    import board_pkg::*;

    logic osd_pause;
    logic pause_toggle;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            flip         <= 1'b0;
            autofire_en  <= 1'b0;
            test         <= 1'b0;
            osd_pause    <= 1'b0;
            pause_toggle <= 1'b0;
        end else begin
            flip        <= status[STATUS_FLIP_BIT];
            autofire_en <= status[STATUS_AUTOFIRE_BIT];
            test        <= status[STATUS_TEST_BIT];
            osd_pause   <= status[STATUS_PAUSE_BIT];
            // One toggle per keyboard pause pulse
            if (key_pause) begin
                pause_toggle <= ~pause_toggle;
            end
        end
    end

    // OSD pause wins over the keyboard state
    assign game_pause = pause_toggle | osd_pause;

endmodule

`default_nettype wire

/* source/player_channel.sv */
//----------------------------------------------------------------------
// Per-player channel: board and keyboard merge, flip mirroring of the
// directions and autofire on button 0
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module player_channel (
    input  logic                    clk_sys,
    input  logic                    rst,
    player_if.sink                  raw,
    input  logic                    flip,
    input  logic                    autofire_en,
    output board_pkg::player_state_t state
);
    import board_pkg::*;

    logic [JOY_W-1:0] merged;
    logic [JOY_W-1:0] mirrored;
    logic             held;
    logic             fire_on;
    logic             phase;

    assign merged  = raw.board_joy | raw.key_joy;
    assign held    = merged[JOY_BTN0];
    assign fire_on = autofire_en & held;

    always_comb begin
        mirrored = merged;
        // Flipped screen turns the stick round
        if (flip) begin
            mirrored[JOY_RIGHT] = merged[JOY_LEFT];
            mirrored[JOY_LEFT]  = merged[JOY_RIGHT];
            mirrored[JOY_DOWN]  = merged[JOY_UP];
            mirrored[JOY_UP]    = merged[JOY_DOWN];
        end
        mirrored[JOY_BTN0] = held & (phase | ~autofire_en);
    end

    // Autofire phase, parked at 1 so a fresh press fires at once
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            phase <= 1'b1;
        end else if (!fire_on) begin
            phase <= 1'b1;
        end else if (raw.frame_tick) begin
            phase <= ~phase;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            state <= '0;
        end else begin
            state.joy   <= mirrored;
            state.coin  <= raw.coin;
            state.start <= raw.start;
        end
    end

    // Released button rearms the phase for the next press
    assert property (@(posedge clk_sys) disable iff (rst) !held |=> phase)
        else $error("autofire phase not rearmed after release");

endmodule

`default_nettype wire

/* source/player_if.sv */
//----------------------------------------------------------------------
// One player's synchronised raw inputs and the frame tick, from the
// sampler to the player channel
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface player_if;
    import board_pkg::*;

    logic [JOY_W-1:0] board_joy;
    logic [JOY_W-1:0] key_joy;
    logic             coin;
    logic             start;
    // Single cycle pulse once per frame
    logic             frame_tick;

    modport source (
        output board_joy, key_joy, coin, start, frame_tick
    );

    modport sink (
        input board_joy, key_joy, coin, start, frame_tick
    );

endinterface

`default_nettype wire

/* tb.f */
+incdir+tests
source/board_pkg.sv
source/player_if.sv
source/input_sampler.sv
source/player_channel.sv
source/osd_dip_decode.sv
source/game_port_mapper.sv
source/board_inputs.sv
tests/tb_board_inputs.sv

/* tests/tb_checks.svh */
//----------------------------------------------------------------------
// Directed tests, expected player states and compare tasks for the
// game input path testbench
//----------------------------------------------------------------------

// Ends 1 ns after a rising edge, where inputs change and outputs are read
task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_sys);
    #1;
endtask

task automatic fail_check(input string msg);
    error_count++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped at the first mismatch");
endtask

task automatic check_player(input player_state_t exp, input int p);
    player_state_t got;
    // Game ports are active low
    got.joy   = ~game_joy[p];
    got.coin  = ~game_coin[p];
    got.start = ~game_start[p];
    if (got !== exp) begin
        fail_check($sformatf("player %0d joy %h coin %b start %b, expected %h %b %b",
            p + 1, got.joy, got.coin, got.start, exp.joy, exp.coin, exp.start));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_check($sformatf("%s is %b, expected %b", name, got, exp));
    end
endtask

// Game side view of the inputs now on the board ports
function automatic player_state_t expected_state(input int p, input logic flipped,
                                                 input logic btn0_gate);
    player_state_t    s;
    logic [JOY_W-1:0] j;
    j     = board_joy[p] | key_joy[p];
    s.joy = j;
    if (flipped) begin
        s.joy[JOY_RIGHT] = j[JOY_LEFT];
        s.joy[JOY_LEFT]  = j[JOY_RIGHT];
        s.joy[JOY_DOWN]  = j[JOY_UP];
        s.joy[JOY_UP]    = j[JOY_DOWN];
    end
    s.joy[JOY_BTN0] = j[JOY_BTN0] & btn0_gate;
    s.coin          = board_coin[p];
    s.start         = board_start[p];
    return s;
endfunction

task automatic check_players(input logic flipped, input logic btn0_gate);
    for (int p = 0; p < NUM_PLAYERS; p++) begin
        check_player(expected_state(p, flipped, btn0_gate), p);
    end
endtask

task automatic check_idle();
    for (int p = 0; p < NUM_PLAYERS; p++) begin
        check_player('0, p);
    end
endtask

task automatic clear_inputs();
    for (int p = 0; p < NUM_PLAYERS; p++) begin
        board_joy[p] = '0;
        key_joy[p]   = '0;
    end
    board_coin  = '0;
    board_start = '0;
endtask

task automatic randomize_inputs();
    for (int p = 0; p < NUM_PLAYERS; p++) begin
        board_joy[p] = JOY_W'($urandom);
        key_joy[p]   = JOY_W'($urandom);
    end
    board_coin  = NUM_PLAYERS'($urandom);
    board_start = NUM_PLAYERS'($urandom);
endtask

task automatic pulse_key_pause();
    key_pause = 1'b1;
    wait_cycles(1);
    key_pause = 1'b0;
    wait_cycles(STATUS_CYCLES - 1);
endtask

task automatic test_reset_and_merge();
    player_state_t prev [NUM_PLAYERS];
    check_idle();
    check_flag("dip_pause", dip_pause, 1'b0);
    check_flag("dip_test", dip_test, 1'b0);
    repeat (64) begin
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            prev[p] = expected_state(p, 1'b0, 1'b1);
        end
        randomize_inputs();
        // One cycle early the outputs still show the previous inputs
        wait_cycles(PATH_CYCLES - 1);
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            check_player(prev[p], p);
        end
        wait_cycles(1);
        check_players(1'b0, 1'b1);
    end
endtask

task automatic test_flip();
    status[STATUS_FLIP_BIT] = 1'b1;
    // Single directions first, then random diagonals
    for (int d = 0; d < 12; d++) begin
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            board_joy[p] = (d < 4) ? JOY_W'(1 << ((d + p) % 4)) : JOY_W'($urandom);
            key_joy[p]   = JOY_W'($urandom) & BTN_MASK;
        end
        wait_cycles(PATH_CYCLES);
        check_players(1'b1, 1'b1);
    end
    status[STATUS_FLIP_BIT] = 1'b0;
    clear_inputs();
    wait_cycles(PATH_CYCLES);
endtask

task automatic press_button0();
    for (int p = 0; p < NUM_PLAYERS; p++) begin
        if (p % 2 == 0) begin
            board_joy[p] = BTN0_HELD;
        end else begin
            key_joy[p] = BTN0_HELD;
        end
    end
endtask

task automatic test_autofire();
    logic phase;
    status[STATUS_AUTOFIRE_BIT] = 1'b1;
    press_button0();
    wait_cycles(PATH_CYCLES);
    phase = 1'b1;
    check_players(1'b0, phase);
    // Odd frame count leaves the phase low before the release
    repeat (25) begin
        vs = 1'b1;
        wait_cycles(VS_HALF);
        vs = 1'b0;
        wait_cycles(VS_HALF);
        // Button 0 changes once per frame
        phase = ~phase;
        check_players(1'b0, phase);
    end
    clear_inputs();
    wait_cycles(PATH_CYCLES);
    check_idle();
    press_button0();
    wait_cycles(PATH_CYCLES);
    check_players(1'b0, 1'b1);
    status[STATUS_AUTOFIRE_BIT] = 1'b0;
    clear_inputs();
    wait_cycles(PATH_CYCLES);
endtask

task automatic test_download_lock();
    randomize_inputs();
    wait_cycles(PATH_CYCLES);
    check_players(1'b0, 1'b1);
    downloading = 1'b1;
    repeat (8) begin
        wait_cycles(PATH_CYCLES);
        check_idle();
        randomize_inputs();
    end
    downloading = 1'b0;
    wait_cycles(PATH_CYCLES);
    check_players(1'b0, 1'b1);
    clear_inputs();
    wait_cycles(PATH_CYCLES);
endtask

task automatic test_pause_and_test();
    logic exp_pause;
    exp_pause = 1'b0;
    repeat (4) begin
        pulse_key_pause();
        exp_pause = ~exp_pause;
        check_flag("dip_pause", dip_pause, exp_pause);
    end
    // OSD pause holds the game paused whatever the keyboard does
    status[STATUS_PAUSE_BIT] = 1'b1;
    wait_cycles(STATUS_CYCLES);
    check_flag("dip_pause", dip_pause, 1'b1);
    repeat (2) begin
        pulse_key_pause();
        check_flag("dip_pause", dip_pause, 1'b1);
    end
    status[STATUS_PAUSE_BIT] = 1'b0;
    wait_cycles(STATUS_CYCLES);
    check_flag("dip_pause", dip_pause, 1'b0);
    status[STATUS_TEST_BIT] = 1'b1;
    wait_cycles(STATUS_CYCLES);
    check_flag("dip_test", dip_test, 1'b1);
    status[STATUS_TEST_BIT] = 1'b0;
    wait_cycles(STATUS_CYCLES);
    check_flag("dip_test", dip_test, 1'b0);
endtask

/* tests/tb_board_inputs.sv */
//----------------------------------------------------------------------
// Testbench top for the game input path: clock, reset, DUT instance,
// timeout and the directed test sequence
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_board_inputs;
    import board_pkg::*;

    localparam logic [31:0] RNG_SEED = 32'h59e7_5303;
    // Whole sequence runs about 600 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    // Latencies in clk_sys cycles
    localparam int PATH_CYCLES   = 4;
    localparam int STATUS_CYCLES = 2;
    localparam int VS_HALF       = 4;

    localparam logic [JOY_W-1:0] BTN_MASK  = {{(JOY_W-4){1'b1}}, 4'b0000};
    localparam logic [JOY_W-1:0] BTN0_HELD = JOY_W'(3) << JOY_BTN0;

    logic                   clk_sys;
    logic                   rst;
    logic                   vs;
    logic                   downloading;
    logic [JOY_W-1:0]       board_joy [NUM_PLAYERS];
    logic [JOY_W-1:0]       key_joy [NUM_PLAYERS];
    logic [NUM_PLAYERS-1:0] board_coin;
    logic [NUM_PLAYERS-1:0] board_start;
    logic [STATUS_W-1:0]    status;
    logic                   key_pause;
    logic [JOY_W-1:0]       game_joy [NUM_PLAYERS];
    logic [NUM_PLAYERS-1:0] game_coin;
    logic [NUM_PLAYERS-1:0] game_start;
    logic                   dip_pause;
    logic                   dip_test;
    int                     cycle_count = 0;
    int                     error_count = 0;

    `include "tb_checks.svh"

    board_inputs #(
        .ACTIVE_LOW (1)
    ) i_board_inputs (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .vs              (vs),
        .downloading     (downloading),
        .board_joystick1 (board_joy[0]),
        .board_joystick2 (board_joy[1]),
        .board_joystick3 (board_joy[2]),
        .board_joystick4 (board_joy[3]),
        .key_joystick1   (key_joy[0]),
        .key_joystick2   (key_joy[1]),
        .key_joystick3   (key_joy[2]),
        .key_joystick4   (key_joy[3]),
        .board_coin      (board_coin),
        .board_start     (board_start),
        .status          (status),
        .key_pause       (key_pause),
        .game_joystick1  (game_joy[0]),
        .game_joystick2  (game_joy[1]),
        .game_joystick3  (game_joy[2]),
        .game_joystick4  (game_joy[3]),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .dip_pause       (dip_pause),
        .dip_test        (dip_test)
    );

    always #5 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "simulation timeout");
        end
    end

    initial begin
        void'($urandom(RNG_SEED));
        clk_sys     = 1'b0;
        rst         = 1'b1;
        vs          = 1'b0;
        downloading = 1'b0;
        status      = '0;
        key_pause   = 1'b0;
        clear_inputs();
        wait_cycles(2);
        rst = 1'b0;

        test_reset_and_merge();
        test_flip();
        test_autofire();
        test_download_lock();
        test_pause_and_test();

        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
